/* verilog/nccDataPkg.sv */
package nccDataPkg;

	// pixel geometry of the descriptor stream
	localparam int PixelWidth = 9;
	localparam int PixelsPerWord = 4;

	// patch side used when the top level is not overridden
	localparam int DefaultPatchSide = 16;

	// accumulator and index widths
	localparam int ProductWidth = 2 * PixelWidth;
	localparam int ScoreWidth = 32;
	localparam int WindowIndexWidth = 9;

	// one signed pixel, descriptor or window
	typedef logic signed [PixelWidth-1:0] pixelT;

	// packed descriptor word, pixel 0 in the top bits
	typedef logic [PixelsPerWord*PixelWidth-1:0] descWordT;

	// exact product of two pixels
	typedef logic signed [ProductWidth-1:0] productT;

	// row total or full window score
	typedef logic signed [ScoreWidth-1:0] scoreT;

	// window number within a frame
	typedef logic [WindowIndexWidth-1:0] windowIndexT;

endpackage

/* verilog/nccCtrlPkg.sv */
package nccCtrlPkg;

	// windows per frame before the index wraps
	localparam int DefaultWindowsPerFrame = 150;

	// window handling FSM
	// WinWait idles until a window is offered,
	// WinScore commits the score one cycle later
	typedef enum logic {
		WinWait = 1'b0,
		WinScore = 1'b1
	} winStateT;

endpackage

/* verilog/descLoader.sv */
`timescale 1ns/1ns

module descLoader import nccDataPkg::*; #(
	parameter int PatchSide = 16
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	input descWordT descWord,
	output pixelT [PixelsPerWord-1:0] cellPixels,
	output logic [PatchSide-1:0] rowWrite,
	output logic [PatchSide/PixelsPerWord-1:0] groupWrite
);

	localparam int Groups = PatchSide / PixelsPerWord;
	localparam int GroupBits = (Groups > 1) ? $clog2(Groups) : 1;
	localparam int RowBits = $clog2(PatchSide);

	logic [RowBits-1:0] rowCount;
	logic [GroupBits-1:0] groupCount;
	logic lastGroup;
	logic lastRow;

	assign lastGroup = (groupCount == GroupBits'(Groups - 1));
	assign lastRow = (rowCount == RowBits'(PatchSide - 1));

	// group steps on every word, row steps when the group wraps
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rowCount <= '0;
			groupCount <= '0;
		end else if (descValid) begin
			if (lastGroup) begin
				groupCount <= '0;
				rowCount <= lastRow ? '0 : rowCount + 1'b1;
			end else begin
				groupCount <= groupCount + 1'b1;
			end
		end
	end

	// split the word, pixel 0 from the top bits
	always_comb begin
		cellPixels = '0;
		if (descValid) begin
			for (int p = 0; p < PixelsPerWord; p++) begin
				cellPixels[p] = descWord[(PixelsPerWord-1-p)*PixelWidth +: PixelWidth];
			end
		end
	end

	// one-hot enables, only while a word is present
	always_comb begin
		rowWrite = '0;
		groupWrite = '0;
		if (descValid) begin
			rowWrite[rowCount] = 1'b1;
			groupWrite[groupCount] = 1'b1;
		end
	end

	// a write always targets exactly one row and one group together
	assert property (@(posedge clk) disable iff (rst)
		$onehot0(rowWrite) && $onehot0(groupWrite)
		&& ((rowWrite != '0) == (groupWrite != '0)));

endmodule

/* verilog/matchRow.sv */
`timescale 1ns/1ns

module matchRow import nccDataPkg::*; #(
	parameter int PatchSide = 16
) (
	input logic clk,
	input logic rst,
	input pixelT [PixelsPerWord-1:0] cellPixels,
	input logic rowSelect,
	input logic [PatchSide/PixelsPerWord-1:0] groupWrite,
	input logic loadWindow,
	input pixelT [PatchSide-1:0] rowWindow,
	output scoreT rowTotal
);

	// running sum entering each column, column 0 starts from zero
	scoreT partialSum [PatchSide+1];

	assign partialSum[0] = '0;

	for (genvar c = 0; c < PatchSide; c++) begin : gCell
		pixelT descPix;
		pixelT winPix;
		productT product;

		// descriptor pixel, written by its row and column group
		always_ff @(posedge clk, posedge rst) begin
			if (rst) begin
				descPix <= '0;
			end else if (rowSelect && groupWrite[c / PixelsPerWord]) begin
				descPix <= cellPixels[c % PixelsPerWord];
			end
		end

		// window pixel, loaded for the whole patch at once
		always_ff @(posedge clk, posedge rst) begin
			if (rst) begin
				winPix <= '0;
			end else if (loadWindow) begin
				winPix <= rowWindow[c];
			end
		end

		// exact signed multiply, then chain into the next column
		assign product = descPix * winPix;
		assign partialSum[c+1] = partialSum[c] + product;
	end

	assign rowTotal = partialSum[PatchSide];

endmodule

/* verilog/correlationArray.sv */
`timescale 1ns/1ns

module correlationArray import nccDataPkg::*; #(
	parameter int PatchSide = 16
) (
	input logic clk,
	input logic rst,
	input pixelT [PixelsPerWord-1:0] cellPixels,
	input logic [PatchSide-1:0] rowWrite,
	input logic [PatchSide/PixelsPerWord-1:0] groupWrite,
	input logic loadWindow,
	input pixelT [PatchSide*PatchSide-1:0] windowPixels,
	output scoreT windowScore
);

	scoreT rowTotal [PatchSide];

	// one row of cells per patch row
	for (genvar r = 0; r < PatchSide; r++) begin : gRow
		matchRow #(
			.PatchSide(PatchSide)
		) uRow (
			.clk(clk),
			.rst(rst),
			.cellPixels(cellPixels),
			.rowSelect(rowWrite[r]),
			.groupWrite(groupWrite),
			.loadWindow(loadWindow),
			.rowWindow(windowPixels[r*PatchSide +: PatchSide]),
			.rowTotal(rowTotal[r])
		);
	end

	// add the row totals into the window score
	always_comb begin
		windowScore = '0;
		for (int r = 0; r < PatchSide; r++) begin
			windowScore = windowScore + rowTotal[r];
		end
	end

endmodule

/* verilog/bestMatchTracker.sv */
`timescale 1ns/1ns

module bestMatchTracker import nccDataPkg::*, nccCtrlPkg::*; #(
	parameter int WindowsPerFrame = 150
) (
	input logic clk,
	input logic rst,
	input logic windowReady,
	input scoreT windowScore,
	output logic loadWindow,
	output logic windowDone,
	output scoreT bestScore,
	output windowIndexT bestIndex
);

	localparam windowIndexT LastWindow = windowIndexT'(WindowsPerFrame - 1);

	winStateT state;
	winStateT nextState;
	windowIndexT windowCount;
	logic scoreCommit;
	logic newBest;

	// window FSM outputs and next state
	always_comb begin
		loadWindow = 1'b0;
		scoreCommit = 1'b0;
		nextState = state;
		case (state)
			WinWait: begin
				if (windowReady) begin
					loadWindow = 1'b1;
					nextState = WinScore;
				end
			end
			WinScore: begin
				scoreCommit = 1'b1;
				nextState = WinWait;
			end
			default: begin
				nextState = WinWait;
			end
		endcase
	end

	assign windowDone = scoreCommit;

	// strictly greater, so a tie keeps the earlier window
	assign newBest = (windowScore > bestScore);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= WinWait;
		end else begin
			state <= nextState;
		end
	end

	// window count wraps at the end of each frame
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			windowCount <= '0;
		end else if (scoreCommit) begin
			if (windowCount == LastWindow) begin
				windowCount <= '0;
			end else begin
				windowCount <= windowCount + 1'b1;
			end
		end
	end

	// best score and the window that produced it
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (scoreCommit && newBest) begin
			bestScore <= windowScore;
			bestIndex <= windowCount;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		windowCount < windowIndexT'(WindowsPerFrame));

	// the producer only sees one done pulse per window
	assert property (@(posedge clk) disable iff (rst)
		windowDone |=> !windowDone);

endmodule

/* verilog/nccMatcher.sv */
`timescale 1ns/1ns

module nccMatcher import nccDataPkg::*, nccCtrlPkg::*; #(
	parameter int PatchSide = DefaultPatchSide,
	parameter int WindowsPerFrame = DefaultWindowsPerFrame
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	input descWordT descWord,
	input logic windowReady,
	input pixelT [PatchSide*PatchSide-1:0] windowPixels,
	output logic windowDone,
	output scoreT bestScore,
	output windowIndexT bestIndex
);

	// descriptor write path
	pixelT [PixelsPerWord-1:0] cellPixels;
	logic [PatchSide-1:0] rowWrite;
	logic [PatchSide/PixelsPerWord-1:0] groupWrite;

	// window scoring path
	logic loadWindow;
	scoreT windowScore;

	descLoader #(
		.PatchSide(PatchSide)
	) uDescLoader (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descWord(descWord),
		.cellPixels(cellPixels),
		.rowWrite(rowWrite),
		.groupWrite(groupWrite)
	);

	correlationArray #(
		.PatchSide(PatchSide)
	) uCorrelationArray (
		.clk(clk),
		.rst(rst),
		.cellPixels(cellPixels),
		.rowWrite(rowWrite),
		.groupWrite(groupWrite),
		.loadWindow(loadWindow),
		.windowPixels(windowPixels),
		.windowScore(windowScore)
	);

	bestMatchTracker #(
		.WindowsPerFrame(WindowsPerFrame)
	) uBestMatchTracker (
		.clk(clk),
		.rst(rst),
		.windowReady(windowReady),
		.windowScore(windowScore),
		.loadWindow(loadWindow),
		.windowDone(windowDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule

/* tests/nccModel.svh */
`ifndef nccModelSvh
`define nccModelSvh

// descriptor pixels as the cells should hold them at row*PatchSide+col
int modelDesc [NumPixels];
int modelWordCount;
int modelBest;
int modelIndex;
int modelCount;
logic [15:0] lfsrState;

// fibonacci lfsr with taps 16 14 13 11
function automatic logic stepLfsr();
	logic feedback;
	feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
	lfsrState = {lfsrState[14:0], feedback};
	return feedback;
endfunction

// one signed pixel from one lfsr step per bit
function automatic int randomPixel();
	logic [PixelWidth-1:0] bits;
	bits = '0;
	for (int b = 0; b < PixelWidth; b++) begin
		bits = {bits[PixelWidth-2:0], stepLfsr()};
	end
	return int'($signed(bits));
endfunction

function automatic void resetModel();
	for (int i = 0; i < NumPixels; i++) begin
		modelDesc[i] = 0;
	end
	modelWordCount = 0;
	modelBest = 0;
	modelIndex = 0;
	modelCount = 0;
endfunction

// words fill a row group by group with pixel 0 from the top bits
function automatic void storeDescWord(descWordT word);
	int row;
	int group;
	row = modelWordCount / Groups;
	group = modelWordCount % Groups;
	for (int p = 0; p < PixelsPerWord; p++) begin
		modelDesc[row*PatchSide + group*PixelsPerWord + p] =
			int'($signed(word[(PixelsPerWord-1-p)*PixelWidth +: PixelWidth]));
	end
	modelWordCount = (modelWordCount + 1) % WordsPerDesc;
endfunction

function automatic int expectedScore(input int win [NumPixels]);
	int sum;
	sum = 0;
	for (int i = 0; i < NumPixels; i++) begin
		sum += modelDesc[i] * win[i];
	end
	return sum;
endfunction

// strictly greater wins and the counter wraps at the frame end
function automatic bit commitWindow(int score);
	bit updated;
	updated = (score > modelBest);
	if (updated) begin
		modelBest = score;
		modelIndex = modelCount;
	end
	if (modelCount == WindowsPerFrame - 1) begin
		modelCount = 0;
	end else begin
		modelCount++;
	end
	return updated;
endfunction

`endif

/* tests/tbNccMatcher.sv */
`timescale 1ns/1ns

module tbNccMatcher import nccDataPkg::*, nccCtrlPkg::*; ();

	localparam int PatchSide = DefaultPatchSide;
	localparam int WindowsPerFrame = DefaultWindowsPerFrame;
	localparam int NumPixels = PatchSide * PatchSide;
	localparam int Groups = PatchSide / PixelsPerWord;
	localparam int WordsPerDesc = NumPixels / PixelsPerWord;
	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 4;
	localparam int DoneTimeout = 8;
	localparam int RandomWindows = 300;
	localparam int ReloadWindows = 40;
	// first window, random run, reload run plus self window, three extremes
	localparam int TotalWindows = 1 + RandomWindows + ReloadWindows + 1 + 3;
	localparam int TotalDescWords = 4 * WordsPerDesc;
	localparam int WatchdogCycles = TotalDescWords * 2 + TotalWindows * 4 + 100;

	logic clk;
	logic rst;
	logic descValid;
	descWordT descWord;
	logic windowReady;
	pixelT [NumPixels-1:0] windowPixels;
	logic windowDone;
	scoreT bestScore;
	windowIndexT bestIndex;

	int checkCount;
	int mismatchCount;
	int failCount;
	int winArr [NumPixels];
	// last window that set a new best is offered again for ties
	int tieWin [NumPixels];

	`include "nccModel.svh"

	nccMatcher #(
		.PatchSide(PatchSide),
		.WindowsPerFrame(WindowsPerFrame)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descWord(descWord),
		.windowReady(windowReady),
		.windowPixels(windowPixels),
		.windowDone(windowDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	always #(ClockPeriod / 2) clk = ~clk;

	task automatic compareValue(input string name, input int expected, input int actual);
		checkCount++;
		if (expected != actual) begin
			mismatchCount++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// one full descriptor at one word per clock
	task automatic loadDescriptor(input bit useRandom, input int fill);
		descWordT word;
		int pix;
		for (int w = 0; w < WordsPerDesc; w++) begin
			word = '0;
			for (int p = 0; p < PixelsPerWord; p++) begin
				if (useRandom) begin
					pix = randomPixel();
				end else begin
					pix = fill;
				end
				word[(PixelsPerWord-1-p)*PixelWidth +: PixelWidth] = pix[PixelWidth-1:0];
			end
			storeDescWord(word);
			@(posedge clk);
			descValid <= 1'b1;
			descWord <= word;
		end
		@(posedge clk);
		descValid <= 1'b0;
	endtask

	task automatic fillWindow(input bit useRandom, input int fill);
		for (int i = 0; i < NumPixels; i++) begin
			if (useRandom) begin
				winArr[i] = randomPixel();
			end else begin
				winArr[i] = fill;
			end
		end
	endtask

	// offer winArr, wait for done, then check the best register
	task automatic offerWindow(input string name);
		pixelT [NumPixels-1:0] packedWin;
		int score;
		int waited;
		bit seen;
		bit updated;
		for (int i = 0; i < NumPixels; i++) begin
			packedWin[i] = pixelT'(winArr[i]);
		end
		score = expectedScore(winArr);
		@(posedge clk);
		windowReady <= 1'b1;
		windowPixels <= packedWin;
		@(posedge clk);
		windowReady <= 1'b0;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < DoneTimeout) begin
			@(negedge clk);
			waited++;
			if (windowDone) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			failCount++;
			$display("error: %s got no windowDone within %0d cycles", name, DoneTimeout);
		end else begin
			compareValue({name, " doneLatency"}, 1, waited);
			updated = commitWindow(score);
			if (updated) begin
				tieWin = winArr;
			end
			@(posedge clk);
			@(negedge clk);
			compareValue({name, " donePulse"}, 0, int'(windowDone));
			compareValue({name, " bestScore"}, modelBest, int'(bestScore));
			compareValue({name, " bestIndex"}, modelIndex, int'(bestIndex));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		descValid = 1'b0;
		descWord = '0;
		windowReady = 1'b0;
		windowPixels = '0;
		checkCount = 0;
		mismatchCount = 0;
		failCount = 0;
		lfsrState = 16'd18071;
		resetModel();
		for (int i = 0; i < NumPixels; i++) begin
			tieWin[i] = 0;
		end

		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compareValue("reset bestScore", 0, int'(bestScore));
		compareValue("reset bestIndex", 0, int'(bestIndex));
		compareValue("reset windowDone", 0, int'(windowDone));

		loadDescriptor(1'b1, 0);
		fillWindow(1'b1, 0);
		offerWindow("firstWindow");

		// every 37th window repeats the best one so a tie must not move the index
		for (int n = 0; n < RandomWindows; n++) begin
			if (n % 37 == 36) begin
				winArr = tieWin;
			end else begin
				fillWindow(1'b1, 0);
			end
			offerWindow("randomWindow");
		end

		loadDescriptor(1'b1, 0);
		for (int n = 0; n < ReloadWindows; n++) begin
			fillWindow(1'b1, 0);
			offerWindow("reloadWindow");
		end
		// autocorrelation only peaks if word order matched
		winArr = modelDesc;
		offerWindow("selfWindow");

		// signed extremes of product and sum
		loadDescriptor(1'b0, 255);
		fillWindow(1'b0, 255);
		offerWindow("maxPositive");
		loadDescriptor(1'b0, -256);
		offerWindow("mixedSign");
		fillWindow(1'b0, -256);
		offerWindow("maxNegative");

		$display("checks %0d, mismatches %0d, other errors %0d",
			checkCount, mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("error: watchdog timeout after %0d cycles", WatchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+tests
verilog/nccDataPkg.sv
verilog/nccCtrlPkg.sv
verilog/descLoader.sv
verilog/matchRow.sv
verilog/correlationArray.sv
verilog/bestMatchTracker.sv
verilog/nccMatcher.sv
tests/tbNccMatcher.sv

/* run.sh */
#!/bin/sh
# build and run the matcher testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbNccMatcher -f all.f -o simNcc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simNcc > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
